// File: Bender.yml
package:
  name: ooo_backend

sources:
  - files:
      - verilog/ooo_types_pkg.sv
      - verilog/circular_queue.sv
      - verilog/dispatch_stage.sv
      - verilog/exec_unit.sv
      - verilog/rob.sv
      - verilog/commit_stage.sv
      - verilog/ooo_backend.sv
  - target: simulation
    files:
      - verification/ooo_backend_checker.sv
      - verification/ooo_backend_tb.sv

// File: ooo_backend.f
verilog/ooo_types_pkg.sv
verilog/circular_queue.sv
verilog/dispatch_stage.sv
verilog/exec_unit.sv
verilog/rob.sv
verilog/commit_stage.sv
verilog/ooo_backend.sv
verification/ooo_backend_checker.sv
verification/ooo_backend_tb.sv

// File: verification/ooo_backend_checker.sv
`timescale 1ns/1ps

module ooo_backend_checker
    import ooo_types_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               dispatch_valid,
    input logic               dispatch_stall,
    input logic               commit_valid,
    input logic [reg_w-1:0]   commit_rd [ss],
    input logic [data_w-1:0]  commit_value [ss],
    input logic [order_w-1:0] commit_order [ss]
);

    // A full ROB holds rob_depth/ss pairs, one more pair waits in dispatch
    localparam int full_in_flight = rob_depth / ss + 1;

    logic [reg_w-1:0]   exp_rd_q [$];
    logic [data_w-1:0]  exp_value_q [$];
    logic [order_w-1:0] next_order = '0;
    logic               seen_dispatch = 1'b0;
    int commit_count = 0;
    int accepted_count = 0;
    int value_errors = 0;
    int rd_errors = 0;
    int order_errors = 0;
    int idle_errors = 0;
    int extra_errors = 0;
    int fill_stalls = 0;
    int collision_stalls = 0;

    // Expected instructions in program order, lane 0 before lane 1
    function automatic void expect_instr(input logic [reg_w-1:0] rd,
                                         input logic [data_w-1:0] value);
        exp_rd_q.push_back(rd);
        exp_value_q.push_back(value);
    endfunction

    task automatic check_commit();
        logic [reg_w-1:0]   want_rd;
        logic [data_w-1:0]  want_value;
        logic [order_w-1:0] want_order;
        for (int l = 0; l < ss; l++) begin
            want_order = next_order + order_w'(l);
            if (exp_rd_q.size() == 0) begin
                extra_errors++;
                $display("Error at %0t: lane %0d committed with no instruction left to retire",
                         $time, l);
            end else begin
                want_rd    = exp_rd_q.pop_front();
                want_value = exp_value_q.pop_front();
                if (commit_value[l] !== want_value) begin
                    value_errors++;
                    $display("Mismatch at %0t: commit %0d lane %0d value %h, expected %h",
                             $time, commit_count, l, commit_value[l], want_value);
                end
                if (commit_rd[l] !== want_rd) begin
                    rd_errors++;
                    $display("Mismatch at %0t: commit %0d lane %0d rd %0d, expected %0d",
                             $time, commit_count, l, commit_rd[l], want_rd);
                end
            end
            if (commit_order[l] !== want_order) begin
                order_errors++;
                $display("Mismatch at %0t: commit %0d lane %0d order %0d, expected %0d",
                         $time, commit_count, l, commit_order[l], want_order);
            end
        end
        next_order = next_order + order_w'(ss);
        commit_count++;
    endtask

    always @(posedge clk) begin
        int in_flight;
        if (!rst) begin
            // A pair on the commit ports has already left the ROB
            in_flight = accepted_count - commit_count - int'(commit_valid);
            if (!seen_dispatch && (commit_valid || dispatch_stall)) begin
                idle_errors++;
                $display("Error at %0t: commit_valid or dispatch_stall high before any dispatch",
                         $time);
            end
            if (dispatch_valid) begin
                seen_dispatch = 1'b1;
            end
            // Too few pairs in flight for a full ROB, so the stall is a writeback collision
            if (dispatch_stall) begin
                if (in_flight < full_in_flight) begin
                    collision_stalls++;
                end else begin
                    fill_stalls++;
                end
            end
            if (dispatch_valid && !dispatch_stall) begin
                accepted_count++;
            end
            if (commit_valid) begin
                check_commit();
            end
        end
    end

    function automatic int show_test(input string name, input bit ok, input string reason);
        if (ok) begin
            $display("PASS %s", name);
            return 0;
        end
        $display("FAIL %s: %s", name, reason);
        return 1;
    endfunction

    function automatic int report_results(input int num_pairs);
        int failed;
        int errors;
        failed = 0;
        errors = value_errors + rd_errors + order_errors + idle_errors + extra_errors;
        failed += show_test("reset_idle", idle_errors == 0,
                            "outputs were active before the first dispatch");
        failed += show_test("commit_values", value_errors == 0 && commit_count > 0,
                            "wrong committed values, or nothing committed at all");
        failed += show_test("program_order", rd_errors == 0 && extra_errors == 0,
                            "instructions retired out of program order or twice");
        failed += show_test("order_numbers", order_errors == 0,
                            "retire order numbers skipped or repeated");
        failed += show_test("rob_fill",
                            fill_stalls > 0 && commit_count == num_pairs && exp_rd_q.size() == 0,
                            "the ROB never filled, or pairs were lost or duplicated");
        failed += show_test("collision",
                            collision_stalls > 0 && value_errors == 0 && rd_errors == 0,
                            "no writeback collision stall was seen, or its results were wrong");
        $display("Tests: 6 run, %0d passed, %0d failed, %0d check errors, %0d of %0d pairs retired",
                 6 - failed, failed, errors, commit_count, num_pairs);
        return failed + errors;
    endfunction

endmodule

// File: verification/ooo_backend_tb.sv
`timescale 1ns/1ps

module ooo_backend_tb
    import ooo_types_pkg::*;
();

    localparam int clk_period = 20;
    localparam int reset_cycles = 8;
    localparam int cycles_per_pair = 40;
    localparam int fields = 5;
    localparam int words_per_pair = fields * ss;
    localparam int max_pairs = 64;

    logic               clk;
    logic               rst;
    logic               dispatch_valid;
    opcode_e            dispatch_op [ss];
    logic [reg_w-1:0]   dispatch_rd [ss];
    logic [data_w-1:0]  dispatch_a [ss];
    logic [data_w-1:0]  dispatch_b [ss];
    logic               dispatch_stall;
    logic               commit_valid;
    logic [reg_w-1:0]   commit_rd [ss];
    logic [data_w-1:0]  commit_value [ss];
    logic [order_w-1:0] commit_order [ss];

    logic [31:0] trace_mem [max_pairs * words_per_pair];
    int          num_pairs;
    logic        trace_loaded;

    always #(clk_period / 2) clk = ~clk;

    ooo_backend i_ooo_backend (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_stall (dispatch_stall),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_order   (commit_order)
    );

    ooo_backend_checker i_checker (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_stall (dispatch_stall),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_order   (commit_order)
    );

    // Fields of a lane are op, rd, a, b, expected
    function automatic logic [31:0] trace_word(input int pair, input int lane, input int field);
        return trace_mem[pair * words_per_pair + lane * fields + field];
    endfunction

    function automatic logic pair_has_mul(input int pair);
        logic found;
        found = 1'b0;
        for (int l = 0; l < ss; l++) begin
            if (trace_word(pair, l, 0) == 32'(op_mul)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic load_trace();
        // Words past the trace keep an address-based marker that is no valid opcode
        for (int i = 0; i < max_pairs * words_per_pair; i++) begin
            trace_mem[i] = 32'hffff_0000 | 32'(i);
        end
        $readmemh("verification/ooo_backend_trace.txt", trace_mem);
        num_pairs = 0;
        while (num_pairs < max_pairs && trace_word(num_pairs, 0, 0) <= 32'(op_mul)) begin
            num_pairs++;
        end
        trace_loaded = 1'b1;
    endtask

    // Starts at a falling edge, returns at the falling edge after the pair was taken
    task automatic drive_pair(input int pair);
        logic [2:0] op_bits;
        dispatch_valid = 1'b1;
        for (int l = 0; l < ss; l++) begin
            op_bits        = 3'(trace_word(pair, l, 0));
            dispatch_op[l] = opcode_e'(op_bits);
            dispatch_rd[l] = reg_w'(trace_word(pair, l, 1));
            dispatch_a[l]  = trace_word(pair, l, 2);
            dispatch_b[l]  = trace_word(pair, l, 3);
            i_checker.expect_instr(reg_w'(trace_word(pair, l, 1)), trace_word(pair, l, 4));
        end
        // Stall only moves after a rising edge, so it is settled here
        while (dispatch_stall) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        int gap;
        int failed;
        void'($urandom(66552));
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        trace_loaded   = 1'b0;
        for (int l = 0; l < ss; l++) begin
            dispatch_op[l] = op_add;
            dispatch_rd[l] = '0;
            dispatch_a[l]  = '0;
            dispatch_b[l]  = '0;
        end
        load_trace();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        // Quiet cycles after reset before the first pair
        repeat (4) @(negedge clk);
        for (int p = 0; p < num_pairs; p++) begin
            drive_pair(p);
            // Multiply pairs are followed back to back, so bursts fill the ROB
            if (!pair_has_mul(p)) begin
                gap            = 1 + int'($urandom % 3);
                dispatch_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
        end
        dispatch_valid = 1'b0;
        wait (i_checker.commit_count >= num_pairs);
        // A few more cycles so a duplicate commit would still show up
        repeat (10) @(negedge clk);
        failed = i_checker.report_results(num_pairs);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        time limit;
        wait (trace_loaded === 1'b1);
        limit = (reset_cycles + cycles_per_pair * num_pairs) * clk_period;
        #(limit);
        $display("Watchdog expired at %0t: commits never finished, %0d of %0d pairs retired",
                 $time, i_checker.commit_count, num_pairs);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verification/ooo_backend_trace.txt
// One pair per line, lane 0 then lane 1, each lane as: op rd a b expected (all hex)
// op codes: 0 add, 1 sub, 2 and, 3 xor, 4 mul (product wraps to 32 bits)
0 01 00000005 00000003 00000008  1 02 00000010 00000004 0000000c
2 03 0000ffff 00f0f0f0 0000f0f0  3 04 aaaa5555 ffff0000 55555555
1 05 00000001 00000002 ffffffff  0 06 ffffffff 00000002 00000001
4 07 00000006 00000007 0000002a  0 08 00000100 00000001 00000101
0 09 00000002 00000002 00000004  3 0a 0000000f 00000005 0000000a
2 0b 12345678 0000ffff 00005678  0 0c 7fffffff 00000001 80000000
3 0d 0f0f0f0f f0f0f0f0 ffffffff  1 0e 00000064 00000014 00000050
4 0f 80000001 00000002 00000002  4 10 ffffffff ffffffff 00000001
4 11 00010000 00010000 00000000  0 12 00000007 00000008 0000000f
0 13 00000003 00000004 00000007  0 14 0000000a 0000000b 00000015
1 15 00000000 00000001 ffffffff  3 16 12345678 12345678 00000000
2 17 ffffffff 0000abcd 0000abcd  0 18 00001000 00000234 00001234
4 19 00000003 00000005 0000000f  4 1a 0000000c 0000000c 00000090
4 1b 00001000 00001000 01000000  4 1c 00000100 00000100 00010000
4 1d 12345678 00000010 23456780  4 1e 00000007 00000009 0000003f
4 1f 10000000 00000010 00000000  4 01 ffffffff 00000002 fffffffe
4 02 0000ffff 0000ffff fffe0001  4 03 00000011 00000011 00000121
4 04 00000002 00000020 00000040  0 05 00000009 00000001 0000000a
0 06 00000050 00000005 00000055  1 07 00000010 00000001 0000000f
3 08 ffff0000 0000ffff ffffffff  2 09 f0f0f0f0 ff00ff00 f000f000
0 0a 00000001 00000001 00000002  1 0b 00000000 00000000 00000000

// File: verilog/circular_queue.sv
`timescale 1ns/1ps

module circular_queue
    import ooo_types_pkg::*;
#(
    parameter int depth = rob_depth,
    parameter int width = data_w
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic                     pop,
    input  logic [width-1:0]         wr_data [ss],
    input  logic [ss-1:0]            set_en,
    input  logic [$clog2(depth)-1:0] set_idx [ss],
    input  logic [width-1:0]         set_data [ss],
    output logic [width-1:0]         head_data [ss],
    output logic [$clog2(depth)-1:0] tail_idx,
    output logic                     full,
    output logic                     empty
);

    localparam int idx_w = $clog2(depth);
    localparam int cnt_w = idx_w + 1;

    logic [width-1:0] mem [depth];
    logic [idx_w-1:0] head;
    logic [idx_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    queue_state_e     state;

    // Pointer arithmetic that also wraps for depths that are not a power of two
    function automatic logic [idx_w-1:0] wrap_add(input logic [idx_w-1:0] ptr, input int off);
        int sum;
        sum = int'(ptr) + off;
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return idx_w'(sum);
    endfunction

    always_comb begin
        count_next = count;
        if (push) begin
            count_next = count_next + cnt_w'(ss);
        end
        if (pop) begin
            count_next = count_next - cnt_w'(ss);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            state <= q_empty;
        end else begin
            if (push) begin
                tail <= wrap_add(tail, ss);
            end
            if (pop) begin
                head <= wrap_add(head, ss);
            end
            count <= count_next;
            // Full means another group of ss entries no longer fits
            if (count_next == '0) begin
                state <= q_empty;
            end else if (count_next > depth - ss) begin
                state <= q_full;
            end else begin
                state <= q_partial;
            end
        end
    end

    // Indexed overwrites and tail pushes never target the same slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < ss; i++) begin
            if (set_en[i]) begin
                mem[set_idx[i]] <= set_data[i];
            end
            if (push) begin
                mem[wrap_add(tail, i)] <= wr_data[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ss; i++) begin
            head_data[i] = mem[wrap_add(head, i)];
        end
    end

    assign tail_idx = tail;
    assign full     = (state == q_full);
    assign empty    = (state == q_empty);

    assert property (@(posedge clk) disable iff (rst) push |-> !full);
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// File: verilog/commit_stage.sv
`timescale 1ns/1ps

module commit_stage
    import ooo_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               head_ready,
    input  logic [reg_w-1:0]   head_rd [ss],
    input  logic [data_w-1:0]  head_value [ss],
    output logic               commit_valid,
    output logic [reg_w-1:0]   commit_rd [ss],
    output logic [data_w-1:0]  commit_value [ss],
    output logic [order_w-1:0] commit_order [ss]
);

    logic [order_w-1:0] order_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            order_count  <= '0;
        end else begin
            commit_valid <= head_ready;
            // One order number per retired instruction
            if (head_ready) begin
                order_count <= order_count + order_w'(ss);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (head_ready) begin
            for (int i = 0; i < ss; i++) begin
                commit_rd[i]    <= head_rd[i];
                commit_value[i] <= head_value[i];
                commit_order[i] <= order_count + order_w'(i);
            end
        end
    end

endmodule

// File: verilog/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage
    import ooo_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_valid,
    input  opcode_e           dispatch_op [ss],
    input  logic [reg_w-1:0]  dispatch_rd [ss],
    input  logic [data_w-1:0] dispatch_a [ss],
    input  logic [data_w-1:0] dispatch_b [ss],
    input  logic              rob_full,
    input  logic [ss-1:0]     mul_busy_late,
    output logic              issue_valid,
    output opcode_e           issue_op [ss],
    output logic [reg_w-1:0]  issue_rd [ss],
    output logic [data_w-1:0] issue_a [ss],
    output logic [data_w-1:0] issue_b [ss],
    output logic              dispatch_stall
);

    logic          held_valid;
    logic [ss-1:0] lane_collision;

    // An ALU op would share the writeback slot with a multiply leaving stage 2
    always_comb begin
        for (int i = 0; i < ss; i++) begin
            lane_collision[i] = (issue_op[i] != op_mul) && mul_busy_late[i];
        end
        issue_valid    = held_valid && !rob_full && (lane_collision == '0);
        dispatch_stall = held_valid && !issue_valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (!dispatch_stall) begin
            held_valid <= dispatch_valid;
        end
    end

    // Pair register, refilled only on an accepting edge
    always_ff @(posedge clk) begin
        if (dispatch_valid && !dispatch_stall) begin
            issue_op <= dispatch_op;
            issue_rd <= dispatch_rd;
            issue_a  <= dispatch_a;
            issue_b  <= dispatch_b;
        end
    end

    // The source keeps a stalled pair on its inputs until it is taken
    for (genvar g = 0; g < ss; g++) begin : g_hold_check
        assert property (@(posedge clk) disable iff (rst)
            dispatch_valid && dispatch_stall |=> dispatch_valid
                && $stable(dispatch_op[g]) && $stable(dispatch_rd[g])
                && $stable(dispatch_a[g]) && $stable(dispatch_b[g]));
    end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import ooo_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  opcode_e             issue_op [ss],
    input  logic [data_w-1:0]   issue_a [ss],
    input  logic [data_w-1:0]   issue_b [ss],
    input  logic [rob_id_w-1:0] alloc_id [ss],
    output logic [ss-1:0]       mul_busy_late,
    output logic [ss-1:0]       cdb_valid,
    output logic [rob_id_w-1:0] cdb_id [ss],
    output logic [data_w-1:0]   cdb_value [ss]
);

    logic [ss-1:0]          alu_valid;
    logic [rob_id_w-1:0]    alu_id [ss];
    logic [data_w-1:0]      alu_value [ss];
    logic [mul_latency-1:0] mul_valid [ss];
    logic [rob_id_w-1:0]    mul_id [ss][mul_latency];
    logic [data_w-1:0]      mul_value [ss][mul_latency];

    function automatic logic [data_w-1:0] alu_result(input opcode_e op,
                                                     input logic [data_w-1:0] a,
                                                     input logic [data_w-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            default: return a + b;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= '0;
            for (int i = 0; i < ss; i++) begin
                mul_valid[i] <= '0;
            end
        end else begin
            for (int i = 0; i < ss; i++) begin
                alu_valid[i] <= issue_valid && (issue_op[i] != op_mul);
                mul_valid[i] <= {mul_valid[i][mul_latency-2:0],
                                 issue_valid && (issue_op[i] == op_mul)};
            end
        end
    end

    // Product is truncated to data_w on entry and then just shifts along
    always_ff @(posedge clk) begin
        for (int i = 0; i < ss; i++) begin
            alu_id[i]       <= alloc_id[i];
            alu_value[i]    <= alu_result(issue_op[i], issue_a[i], issue_b[i]);
            mul_id[i][0]    <= alloc_id[i];
            mul_value[i][0] <= issue_a[i] * issue_b[i];
            for (int s = 1; s < mul_latency; s++) begin
                mul_id[i][s]    <= mul_id[i][s-1];
                mul_value[i][s] <= mul_value[i][s-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ss; i++) begin
            // Stage that reaches the CDB on the same edge as a newly issued ALU op
            mul_busy_late[i] = mul_valid[i][mul_latency-alu_latency-1];
            cdb_valid[i]     = alu_valid[i] || mul_valid[i][mul_latency-1];
            if (mul_valid[i][mul_latency-1]) begin
                cdb_id[i]    = mul_id[i][mul_latency-1];
                cdb_value[i] = mul_value[i][mul_latency-1];
            end else begin
                cdb_id[i]    = alu_id[i];
                cdb_value[i] = alu_value[i];
            end
        end
    end

    for (genvar g = 0; g < ss; g++) begin : g_lane_check
        assert property (@(posedge clk) disable iff (rst)
            !(alu_valid[g] && mul_valid[g][mul_latency-1]));
    end

endmodule

// File: verilog/ooo_backend.sv
`timescale 1ns/1ps

module ooo_backend
    import ooo_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  opcode_e            dispatch_op [ss],
    input  logic [reg_w-1:0]   dispatch_rd [ss],
    input  logic [data_w-1:0]  dispatch_a [ss],
    input  logic [data_w-1:0]  dispatch_b [ss],
    output logic               dispatch_stall,
    output logic               commit_valid,
    output logic [reg_w-1:0]   commit_rd [ss],
    output logic [data_w-1:0]  commit_value [ss],
    output logic [order_w-1:0] commit_order [ss]
);

    logic                issue_valid;
    opcode_e             issue_op [ss];
    logic [reg_w-1:0]    issue_rd [ss];
    logic [data_w-1:0]   issue_a [ss];
    logic [data_w-1:0]   issue_b [ss];
    logic [rob_id_w-1:0] alloc_id [ss];
    logic                rob_full;
    logic [ss-1:0]       mul_busy_late;
    logic [ss-1:0]       cdb_valid;
    logic [rob_id_w-1:0] cdb_id [ss];
    logic [data_w-1:0]   cdb_value [ss];
    logic                head_ready;
    logic [reg_w-1:0]    head_rd [ss];
    logic [data_w-1:0]   head_value [ss];

    dispatch_stage i_dispatch_stage (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .rob_full       (rob_full),
        .mul_busy_late  (mul_busy_late),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_rd       (issue_rd),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .dispatch_stall (dispatch_stall)
    );

    exec_unit i_exec_unit (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .alloc_id      (alloc_id),
        .mul_busy_late (mul_busy_late),
        .cdb_valid     (cdb_valid),
        .cdb_id        (cdb_id),
        .cdb_value     (cdb_value)
    );

    rob i_rob (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_rd    (issue_rd),
        .cdb_valid   (cdb_valid),
        .cdb_id      (cdb_id),
        .cdb_value   (cdb_value),
        .alloc_id    (alloc_id),
        .rob_full    (rob_full),
        .head_ready  (head_ready),
        .head_rd     (head_rd),
        .head_value  (head_value)
    );

    commit_stage i_commit_stage (
        .clk          (clk),
        .rst          (rst),
        .head_ready   (head_ready),
        .head_rd      (head_rd),
        .head_value   (head_value),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_order (commit_order)
    );

endmodule

// File: verilog/ooo_types_pkg.sv
package ooo_types_pkg;

    // Two instructions enter and retire per cycle
    localparam int ss = 2;

    // Reorder buffer geometry
    localparam int rob_depth = 8;
    localparam int rob_id_w = 3;

    // Datapath widths
    localparam int data_w = 32;
    localparam int reg_w = 5;
    localparam int order_w = 64;

    // Execution latencies in cycles from issue to CDB
    localparam int mul_latency = 3;
    localparam int alu_latency = 1;

    // Integer operations understood by the execution lanes
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul
    } opcode_e;

    // Fill level of a circular queue
    typedef enum logic [1:0] {
        q_empty,
        q_partial,
        q_full
    } queue_state_e;

endpackage

// File: verilog/rob.sv
`timescale 1ns/1ps

module rob
    import ooo_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  logic [reg_w-1:0]    issue_rd [ss],
    input  logic [ss-1:0]       cdb_valid,
    input  logic [rob_id_w-1:0] cdb_id [ss],
    input  logic [data_w-1:0]   cdb_value [ss],
    output logic [rob_id_w-1:0] alloc_id [ss],
    output logic                rob_full,
    output logic                head_ready,
    output logic [reg_w-1:0]    head_rd [ss],
    output logic [data_w-1:0]   head_value [ss]
);

    // Result entry is {value, done}
    logic [data_w:0]       result_push [ss];
    logic [data_w:0]       result_set [ss];
    logic [data_w:0]       result_head [ss];
    logic [rob_id_w-1:0]   tail_idx;
    logic                  result_full;
    logic                  result_empty;
    queue_state_e          rob_state;

    always_comb begin
        for (int i = 0; i < ss; i++) begin
            result_push[i] = '0;
            result_set[i]  = {cdb_value[i], 1'b1};
        end
    end

    circular_queue #(
        .depth (rob_depth),
        .width (data_w + 1)
    ) i_result_q (
        .clk       (clk),
        .rst       (rst),
        .push      (issue_valid),
        .pop       (head_ready),
        .wr_data   (result_push),
        .set_en    (cdb_valid),
        .set_idx   (cdb_id),
        .set_data  (result_set),
        .head_data (result_head),
        .tail_idx  (tail_idx),
        .full      (result_full),
        .empty     (result_empty)
    );

    // Destination registers never change after allocation
    circular_queue #(
        .depth (rob_depth),
        .width (reg_w)
    ) i_rd_q (
        .clk       (clk),
        .rst       (rst),
        .push      (issue_valid),
        .pop       (head_ready),
        .wr_data   (issue_rd),
        .set_en    ('0),
        .set_idx   (cdb_id),
        .set_data  (issue_rd),
        .head_data (head_rd),
        .tail_idx  (),
        .full      (),
        .empty     ()
    );

    assign rob_state = result_empty ? q_empty : (result_full ? q_full : q_partial);
    assign rob_full  = (rob_state == q_full);

    always_comb begin
        // Pairs are pushed and popped together, so one non-empty check covers both
        head_ready = (rob_state != q_empty);
        for (int i = 0; i < ss; i++) begin
            alloc_id[i]   = tail_idx + rob_id_w'(i);
            head_ready    = head_ready && result_head[i][0];
            head_value[i] = result_head[i][data_w:1];
        end
    end

endmodule
